// ==== verilog/sat_settings.svh ====
// ======================================
// Global sizing macros for the SAT
// decision block
// ======================================

`ifndef SAT_SETTINGS_SVH
`define SAT_SETTINGS_SVH

// Variables in the solver window
`define SAT_NUM_VARS 8

// Bits per decision level
`define SAT_LVL_WIDTH 16

`endif

// ==== verilog/sat_var_pkg.sv ====
// ======================================
// Variable, level and table types
// ======================================

`default_nettype none

`include "sat_settings.svh"

package sat_var_pkg;

    localparam int NUM_VARS  = `SAT_NUM_VARS;
    localparam int LVL_WIDTH = `SAT_LVL_WIDTH;
    localparam int IDX_WIDTH = $clog2(NUM_VARS);

    // Decision level, unsigned
    typedef logic [LVL_WIDTH-1:0] lvl_t;

    // One bit per variable, one-hot select or mask
    typedef logic [NUM_VARS-1:0] var_vec_t;

    typedef logic [IDX_WIDTH-1:0] var_idx_t;

    // State of a single variable
    typedef struct packed {
        logic assigned;
        logic value;
        logic decided;
        lvl_t lvl;
    } var_state_t;

    // Whole window, entry i is variable i
    typedef var_state_t [NUM_VARS-1:0] var_tab_t;

endpackage

`default_nettype wire

// ==== verilog/sat_cmd_pkg.sv ====
// ======================================
// Command, opcode and decision result types
// ======================================

`default_nettype none

`include "sat_settings.svh"

package sat_cmd_pkg;

    import sat_var_pkg::*;

    typedef enum logic [2:0] {
        OP_NOP       = 3'd0,
        OP_LOAD_LVL  = 3'd1,
        OP_DECIDE    = 3'd2,
        OP_IMPLY     = 3'd3,
        OP_BACKTRACK = 3'd4
    } sat_op_e;

    // Incoming command, lvl is the load or backtrack target
    typedef struct packed {
        sat_op_e  op;
        var_idx_t var_idx;
        logic     value;
        lvl_t     lvl;
    } sat_cmd_t;

    // Retired command as seen by the variable table
    typedef struct packed {
        sat_op_e  op;
        var_vec_t sel;
        logic     value;
        lvl_t     lvl;
        logic     all_assigned;
    } dec_result_t;

    // True for opcodes that do real work
    function automatic logic op_is_live(sat_op_e op);
        case (op)
            OP_LOAD_LVL, OP_DECIDE, OP_IMPLY, OP_BACKTRACK: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/cmd_decode.sv ====
// ======================================
// Stage 1, command strobe register
// ======================================

`timescale 1ns/100ps
`default_nettype none

module cmd_decode import sat_cmd_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     cmd_valid_i,
    input  wire sat_cmd_t cmd_i,

    output logic          valid_o,
    output sat_cmd_t      cmd_o
);

    logic     valid_q;
    sat_cmd_t cmd_q;

    // NOP and undefined opcodes never leave this stage
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= cmd_valid_i && op_is_live(cmd_i.op);
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_valid_i)
        begin
            cmd_q <= cmd_i;
        end
    end

    assign valid_o = valid_q;
    assign cmd_o   = cmd_q;

    // ======================================
    // Checks
    // ======================================

    // Strobed commands from outside carry a defined op
    a_valid_op : assert property (
        @(posedge clk) disable iff (!rst)
        cmd_valid_i |->
            (cmd_i.op inside {OP_NOP, OP_LOAD_LVL, OP_DECIDE, OP_IMPLY, OP_BACKTRACK})
    ) else $error("cmd_decode: valid command with bad op at %0t", $time);

endmodule

`default_nettype wire

// ==== verilog/first_free_finder.sv ====
// ======================================
// Lowest free variable search
// ======================================

`timescale 1ns/100ps
`default_nettype none

module first_free_finder import sat_var_pkg::*;
(
    input  wire var_vec_t free_i,
    output var_vec_t      sel_o,
    output logic          none_o
);

    // Open until a free variable is seen, then selected, then locked out
    typedef enum logic [1:0] {
        LK_OPEN = 2'b00,
        LK_SEL  = 2'b01,
        LK_OUT  = 2'b11
    } lock_e;

    lock_e lock_st [NUM_VARS];

    genvar i;
    generate
        for (i = 0; i < NUM_VARS; i++)
        begin : g_chain
            lock_e prev_st;

            if (i == 0)
            begin : g_head
                assign prev_st = LK_OPEN;
            end
            else
            begin : g_link
                assign prev_st = lock_st[i-1];
            end

            assign lock_st[i] = (prev_st != LK_OPEN) ? LK_OUT :
                                (free_i[i] ? LK_SEL : LK_OPEN);

            assign sel_o[i] = (lock_st[i] == LK_SEL);
        end
    endgenerate

    // Chain still open at the end means nothing was free
    assign none_o = (lock_st[NUM_VARS-1] == LK_OPEN);

endmodule

`default_nettype wire

// ==== verilog/decision_unit.sv ====
// ======================================
// Stage 2, level register and decision logic
// ======================================

`timescale 1ns/100ps
`default_nettype none

module decision_unit import sat_var_pkg::*, sat_cmd_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     valid_i,
    input  wire sat_cmd_t cmd_i,
    input  wire var_vec_t free_i,

    output logic          valid_o,
    output dec_result_t   res_o,
    output lvl_t          cur_lvl_o
);

    lvl_t        lvl_q;
    logic        valid_q;
    dec_result_t res_q;
    dec_result_t res_d;

    var_vec_t    dec_sel;
    logic        dec_none;
    var_vec_t    imp_sel;

    first_free_finder first_free_finder_inst (
        .free_i (free_i),
        .sel_o  (dec_sel),
        .none_o (dec_none)
    );

    // Imply only lands on a variable that is still free
    assign imp_sel = (var_vec_t'(1) << cmd_i.var_idx) & free_i;

    // ======================================
    // Result build
    // ======================================

    always_comb
    begin
        res_d              = '0;
        res_d.op           = cmd_i.op;
        res_d.lvl          = lvl_q;
        case (cmd_i.op)
            OP_LOAD_LVL:
            begin
                res_d.lvl = cmd_i.lvl;
            end
            OP_DECIDE:
            begin
                if (dec_none)
                begin
                    res_d.all_assigned = 1'b1;
                end
                else
                begin
                    res_d.sel   = dec_sel;
                    res_d.value = 1'b0;
                    res_d.lvl   = lvl_t'(lvl_q + 1'b1);
                end
            end
            OP_IMPLY:
            begin
                res_d.sel   = imp_sel;
                res_d.value = cmd_i.value;
            end
            OP_BACKTRACK:
            begin
                res_d.lvl = cmd_i.lvl;
            end
            default:
            begin
                res_d.sel = '0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            valid_q <= 1'b0;
            lvl_q   <= '0;
        end
        else
        begin
            valid_q <= valid_i;
            if (valid_i)
            begin
                lvl_q <= res_d.lvl;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid_i)
        begin
            res_q <= res_d;
        end
    end

    assign valid_o   = valid_q;
    assign res_o     = res_q;
    assign cur_lvl_o = lvl_q;

    // ======================================
    // Checks
    // ======================================

    a_sel_onehot0 : assert property (
        @(posedge clk) disable iff (!rst)
        valid_o |-> $onehot0(res_o.sel)
    ) else $error("decision_unit: select not one-hot at %0t", $time);

    // Backtrack may only go down or stay
    a_bkt_target : assert property (
        @(posedge clk) disable iff (!rst)
        (valid_i && cmd_i.op == OP_BACKTRACK) |-> (cmd_i.lvl <= lvl_q)
    ) else $error("decision_unit: backtrack above level at %0t", $time);

endmodule

`default_nettype wire

// ==== verilog/var_table.sv ====
// ======================================
// Stage 3, per-variable state table
// ======================================

`timescale 1ns/100ps
`default_nettype none

module var_table import sat_var_pkg::*, sat_cmd_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,

    input  wire logic        valid_i,
    input  wire dec_result_t res_i,

    output var_vec_t         free_o,
    output var_tab_t         vars_o
);

    var_tab_t tab_q;
    var_tab_t tab_d;
    var_vec_t held_q;

    // ======================================
    // Next state
    // ======================================

    always_comb
    begin
        tab_d = tab_q;
        if (valid_i)
        begin
            if (res_i.op == OP_BACKTRACK)
            begin
                // Free everything assigned above the target
                for (int i = 0; i < NUM_VARS; i++)
                begin
                    if (tab_q[i].assigned && (tab_q[i].lvl > res_i.lvl))
                    begin
                        tab_d[i] = '0;
                    end
                end
            end
            else
            begin
                for (int i = 0; i < NUM_VARS; i++)
                begin
                    if (res_i.sel[i])
                    begin
                        tab_d[i].assigned = 1'b1;
                        tab_d[i].value    = res_i.value;
                        tab_d[i].decided  = (res_i.op == OP_DECIDE);
                        tab_d[i].lvl      = res_i.lvl;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            tab_q <= '0;
        end
        else
        begin
            tab_q <= tab_d;
        end
    end

    // Forwarded from next state so stage 2 sees this cycle's write
    always_comb
    begin
        for (int i = 0; i < NUM_VARS; i++)
        begin
            free_o[i] = !tab_d[i].assigned;
            held_q[i] = tab_q[i].assigned;
        end
    end

    assign vars_o = tab_q;

    // ======================================
    // Checks
    // ======================================

    // Stage 2 masks against forwarded state, so no write hits a held entry
    a_no_overwrite : assert property (
        @(posedge clk) disable iff (!rst)
        valid_i |-> ((res_i.sel & held_q) == '0)
    ) else $error("var_table: write to assigned variable at %0t", $time);

endmodule

`default_nettype wire

// ==== verilog/sat_decide_top.sv ====
// ======================================
// Decision pipeline top level
// ======================================

`timescale 1ns/100ps
`default_nettype none

module sat_decide_top import sat_var_pkg::*, sat_cmd_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     cmd_valid_i,
    input  wire sat_cmd_t cmd_i,

    output logic          res_valid_o,
    output dec_result_t   res_o,
    output lvl_t          cur_lvl_o,
    output var_tab_t      vars_o
);

    logic        s1_valid;
    sat_cmd_t    s1_cmd;
    logic        s2_valid;
    dec_result_t s2_res;
    var_vec_t    fwd_free;

    cmd_decode cmd_decode_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .valid_o     (s1_valid),
        .cmd_o       (s1_cmd)
    );

    decision_unit decision_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (s1_valid),
        .cmd_i     (s1_cmd),
        .free_i    (fwd_free),
        .valid_o   (s2_valid),
        .res_o     (s2_res),
        .cur_lvl_o (cur_lvl_o)
    );

    var_table var_table_inst (
        .clk     (clk),
        .rst     (rst),
        .valid_i (s2_valid),
        .res_i   (s2_res),
        .free_o  (fwd_free),
        .vars_o  (vars_o)
    );

    assign res_valid_o = s2_valid;
    assign res_o       = s2_res;

endmodule

`default_nettype wire

// ==== dv/tb_sat_decide.sv ====
// ======================================
// Self-checking testbench for the decision
// pipeline, vectors read from a data file
// ======================================

`timescale 1ns/100ps
`default_nettype none

module tb_sat_decide import sat_var_pkg::*, sat_cmd_pkg::*;
;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_VEC    = 64;

    logic        clk;
    logic        rst;
    logic        cmd_valid_i;
    sat_cmd_t    cmd_i;
    logic        res_valid_o;
    dec_result_t res_o;
    lvl_t        cur_lvl_o;
    var_tab_t    vars_o;

    sat_cmd_t vec_cmd [MAX_VEC];
    var_vec_t exp_sel [MAX_VEC];
    lvl_t     exp_lvl [MAX_VEC];
    logic     exp_all [MAX_VEC];
    var_vec_t exp_asg [MAX_VEC];
    var_vec_t exp_val [MAX_VEC];

    // Expected decided flags and levels of the table
    var_vec_t mdl_dec;
    lvl_t     mdl_lvl [NUM_VARS];

    int num_vec   = 0;
    int err_cnt   = 0;
    int chk_cnt   = 0;
    int cycle_cnt = 0;
    bit loaded    = 1'b0;

    // Pending checks, index of the vector and the cycle it is due
    int res_idx_q[$];
    int res_due_q[$];
    int vars_idx_q[$];
    int vars_due_q[$];

    sat_decide_top sat_decide_top_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .cur_lvl_o   (cur_lvl_o),
        .vars_o      (vars_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ======================================
    // Helpers
    // ======================================

    task automatic compare_field(input string what, input int idx,
                                 input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp)
        else
        begin
            err_cnt++;
            $display("ERROR at %0t ns: vector %0d, %s is %0h, expected %0h",
                     $time, idx, what, got, exp);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    rc;
        string line;
        logic [31:0] f [9];
        fd = $fopen("dv/sat_testdata.txt", "r");
        if (fd == 0)
        begin
            err_cnt++;
            $display("Could not open the test data file dv/sat_testdata.txt");
        end
        else
        begin
            while (!$feof(fd) && num_vec < MAX_VEC)
            begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 && line.getc(0) != "#")
                begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (rc == 9)
                    begin
                        vec_cmd[num_vec].op      = sat_op_e'(f[0][2:0]);
                        vec_cmd[num_vec].var_idx = var_idx_t'(f[1]);
                        vec_cmd[num_vec].value   = f[2][0];
                        vec_cmd[num_vec].lvl     = lvl_t'(f[3]);
                        exp_sel[num_vec]         = var_vec_t'(f[4]);
                        exp_lvl[num_vec]         = lvl_t'(f[5]);
                        exp_all[num_vec]         = f[6][0];
                        exp_asg[num_vec]         = var_vec_t'(f[7]);
                        exp_val[num_vec]         = var_vec_t'(f[8]);
                        num_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_result(input int idx);
        logic exp_value;
        // Decide always assigns false, imply carries the commanded value
        exp_value = (vec_cmd[idx].op == OP_DECIDE) ? 1'b0 : vec_cmd[idx].value;
        compare_field("op", idx, res_o.op, vec_cmd[idx].op);
        compare_field("sel", idx, res_o.sel, exp_sel[idx]);
        compare_field("result level", idx, res_o.lvl, exp_lvl[idx]);
        compare_field("all_assigned", idx, res_o.all_assigned, exp_all[idx]);
        compare_field("current level", idx, cur_lvl_o, exp_lvl[idx]);
        if (exp_sel[idx] != '0)
        begin
            compare_field("value", idx, res_o.value, exp_value);
        end
    endtask

    // Backtrack drops entries above the target, a write takes the new level
    task automatic track_var_fields(input int idx);
        if (vec_cmd[idx].op == OP_BACKTRACK)
        begin
            for (int i = 0; i < NUM_VARS; i++)
            begin
                if (mdl_lvl[i] > vec_cmd[idx].lvl)
                begin
                    mdl_dec[i] = 1'b0;
                    mdl_lvl[i] = '0;
                end
            end
        end
        for (int i = 0; i < NUM_VARS; i++)
        begin
            if (exp_sel[idx][i])
            begin
                mdl_dec[i] = (vec_cmd[idx].op == OP_DECIDE);
                mdl_lvl[i] = exp_lvl[idx];
            end
        end
    endtask

    task automatic check_vars(input int idx, input var_vec_t asg_exp,
                              input var_vec_t val_exp);
        var_vec_t asg;
        var_vec_t val;
        var_vec_t dec;
        for (int i = 0; i < NUM_VARS; i++)
        begin
            asg[i] = vars_o[i].assigned;
            val[i] = vars_o[i].value;
            dec[i] = vars_o[i].decided;
        end
        compare_field("assigned mask", idx, asg, asg_exp);
        compare_field("value mask", idx, val, val_exp);
        compare_field("decided mask", idx, dec, mdl_dec);
        for (int i = 0; i < NUM_VARS; i++)
        begin
            compare_field($sformatf("level of variable %0d", i), idx,
                          vars_o[i].lvl, mdl_lvl[i]);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst         <= 1'b0;
        cmd_valid_i <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        mdl_dec = '0;
        for (int i = 0; i < NUM_VARS; i++)
        begin
            mdl_lvl[i] = '0;
        end
        // Idle state right after reset
        repeat (2) @(negedge clk);
        compare_field("level after reset", -1, cur_lvl_o, '0);
        check_vars(-1, '0, '0);
    endtask

    task automatic send_pass(input bit use_gaps);
        int gap;
        for (int i = 0; i < num_vec; i++)
        begin
            @(posedge clk);
            cmd_valid_i <= 1'b1;
            cmd_i       <= vec_cmd[i];
            // Sampled at the next edge, result two edges after that
            if (vec_cmd[i].op != OP_NOP)
            begin
                res_idx_q.push_back(i);
                res_due_q.push_back(cycle_cnt + 3);
            end
            if (use_gaps)
            begin
                gap = $urandom % 4;
                repeat (gap)
                begin
                    @(posedge clk);
                    cmd_valid_i <= 1'b0;
                end
            end
        end
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        while (res_idx_q.size() != 0 || vars_idx_q.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
    endtask

    // ======================================
    // Response monitor
    // ======================================

    always @(negedge clk)
    begin
        int   idx;
        logic due_now;
        due_now = 1'b0;
        if (res_idx_q.size() > 0)
        begin
            due_now = (res_due_q[0] == cycle_cnt);
        end
        if (res_valid_o)
        begin
            assert (due_now)
            else
            begin
                err_cnt++;
                $display("Result strobe at %0t ns does not belong to any command", $time);
            end
            if (res_idx_q.size() > 0)
            begin
                idx = res_idx_q.pop_front();
                void'(res_due_q.pop_front());
                check_result(idx);
                vars_idx_q.push_back(idx);
                vars_due_q.push_back(cycle_cnt + 1);
            end
        end
        else
        begin
            assert (!due_now)
            else
            begin
                err_cnt++;
                $display("No result strobe for vector %0d at %0t ns", res_idx_q[0], $time);
            end
            if (due_now)
            begin
                void'(res_idx_q.pop_front());
                void'(res_due_q.pop_front());
            end
        end
        if (vars_idx_q.size() > 0 && vars_due_q[0] == cycle_cnt)
        begin
            idx = vars_idx_q.pop_front();
            void'(vars_due_q.pop_front());
            track_var_fields(idx);
            check_vars(idx, exp_asg[idx], exp_val[idx]);
        end
    end

    // ======================================
    // Main sequence and watchdog
    // ======================================

    initial
    begin
        int seed;
        rst         = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        seed        = $urandom(32'h5d44);
        load_vectors();
        loaded = 1'b1;
        if (num_vec == 0)
        begin
            err_cnt++;
            $display("No test vectors were read from the data file");
        end
        else
        begin
            // Burst pass, then the same vectors with random idle gaps
            apply_reset();
            send_pass(1'b0);
            apply_reset();
            send_pass(1'b1);
        end
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial
    begin
        int wd_cycles;
        wait (loaded);
        wd_cycles = num_vec * 10 + num_vec * 3 + 60;
        #(wd_cycles * CLK_PERIOD);
        $display("Timeout, the run did not finish within %0d cycles", wd_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/sat_var_pkg.sv
verilog/sat_cmd_pkg.sv
verilog/cmd_decode.sv
verilog/first_free_finder.sv
verilog/decision_unit.sv
verilog/var_table.sv
verilog/sat_decide_top.sv
dv/tb_sat_decide.sv

// ==== Bender.yml ====
package:
  name: sat_decide

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sat_var_pkg.sv
      - verilog/sat_cmd_pkg.sv
      - verilog/cmd_decode.sv
      - verilog/first_free_finder.sv
      - verilog/decision_unit.sv
      - verilog/var_table.sv
      - verilog/sat_decide_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_sat_decide.sv

// ==== dv/sat_testdata.txt ====
# Columns in hex: op var_idx value lvl | exp_sel exp_lvl exp_all_assigned exp_assigned exp_values
# op: 0 nop, 1 load level, 2 decide, 3 imply, 4 backtrack
2 0 0 0000 01 0001 0 01 00
2 0 0 0000 02 0002 0 03 00
2 0 0 0000 04 0003 0 07 00
3 5 1 0000 20 0003 0 27 20
3 3 1 0000 08 0003 0 2f 28
3 5 0 0000 00 0003 0 2f 28
2 0 0 0000 10 0004 0 3f 28
3 6 1 0000 40 0004 0 7f 68
# backtrack to 2, then decide picks the lowest freed variable
4 0 0 0002 00 0002 0 03 00
2 0 0 0000 04 0003 0 07 00
3 2 1 0000 00 0003 0 07 00
2 0 0 0000 08 0004 0 0f 00
3 7 1 0000 80 0004 0 8f 80
2 0 0 0000 10 0005 0 9f 80
2 0 0 0000 20 0006 0 bf 80
2 0 0 0000 40 0007 0 ff 80
# window full, level stays
2 0 0 0000 00 0007 1 ff 80
0 0 0 0000 00 0000 0 00 00
4 0 0 0004 00 0004 0 8f 80
1 0 0 000a 00 000a 0 8f 80
2 0 0 0000 10 000b 0 9f 80
3 6 1 0000 40 000b 0 df c0
2 0 0 0000 20 000c 0 ff c0
4 0 0 0000 00 0000 0 00 00
2 0 0 0000 01 0001 0 01 00
1 0 0 0005 00 0005 0 01 00
2 0 0 0000 02 0006 0 03 00
4 0 0 0005 00 0005 0 01 00
2 0 0 0000 02 0006 0 03 00
